//--- rtl/pipe_ctrl_pkg.sv
// Pipeline control package
// Shared widths, bundles and the flush cause encoding used by the
// hazard tracker, trap unit and pipeline controller
`default_nettype none

package pipe_ctrl_pkg;

  // Fixed datapath widths
  parameter int PC_DW  = 32;
  parameter int REG_AW = 5;

  // ----------------------------------------------------------
  // Decode stage view of the current instruction
  typedef struct packed {
    logic              vld;
    logic              rd_en;
    logic [REG_AW-1:0] rd;
    logic              rs1_en;
    logic [REG_AW-1:0] rs1;
    logic              rs2_en;
    logic [REG_AW-1:0] rs2;
  } dec_t;

  // OITF report to the controller
  typedef struct packed {
    logic related;
    logic empty;
  } oitf_stat_t;

  // Trap unit requests plus its two vectors
  typedef struct packed {
    logic             req;
    logic             mret;
    logic [PC_DW-1:0] mtvec;
    logic [PC_DW-1:0] epc;
  } trap_req_t;

  // One stall level per stage
  typedef struct packed {
    logic pc;
    logic ifu;
    logic de;
    logic alu;
  } stall_t;

  // Fetch redirect, vld is a single cycle pulse
  typedef struct packed {
    logic             vld;
    logic [PC_DW-1:0] pc;
  } redirect_t;

  // ----------------------------------------------------------
  // Last reason the pipe was flushed
  typedef enum logic [2:0] {
    CAUSE_NONE   = 3'd0,
    CAUSE_JUMP   = 3'd1,
    CAUSE_FENCEI = 3'd2,
    CAUSE_IRQ    = 3'd3,
    CAUSE_MRET   = 3'd4
  } flush_cause_e;

endpackage

`default_nettype wire

//--- rtl/oitf_tracker.sv
// Outstanding instruction tracker
// Keeps the rd of every dispatched long-latency instruction in a small
// circular table, flags RAW hazards against decode and reports empty
`timescale 1ns/1ps
`default_nettype none

module oitf_tracker #(
  parameter int OITF_DEPTH = 4
) (
  input  wire                      clk,
  input  wire                      rstn,
  input  pipe_ctrl_pkg::dec_t      dec,
  input  wire                      retire,
  input  wire                      fake_gen,
  output pipe_ctrl_pkg::oitf_stat_t status
);

  localparam int PTR_W = (OITF_DEPTH > 1) ? $clog2(OITF_DEPTH) : 1;
  localparam int CNT_W = $clog2(OITF_DEPTH + 1);

  // ----------------------------------------------------------
  // Table storage
  logic [pipe_ctrl_pkg::REG_AW-1:0] rd_tab [OITF_DEPTH];
  logic [OITF_DEPTH-1:0]            vld_q;
  logic [PTR_W-1:0]                 wr_ptr;
  logic [PTR_W-1:0]                 rd_ptr;
  logic [CNT_W-1:0]                 count;
  logic                             empty_q;

  logic full;
  logic hit;
  logic related;
  logic alloc;
  logic dealloc;
  logic [CNT_W-1:0] count_nxt;

  // Full when every slot holds a pending writer
  assign full = (count == CNT_W'(OITF_DEPTH));

  // ----------------------------------------------------------
  // Source compare against all live entries
  always_comb begin
    hit = 1'b0;
    for (int i = 0; i < OITF_DEPTH; i++) begin
      if (vld_q[i]) begin
        // rs1 match
        if (dec.rs1_en && (rd_tab[i] == dec.rs1)) begin
          hit = 1'b1;
        end
        // rs2 match
        if (dec.rs2_en && (rd_tab[i] == dec.rs2)) begin
          hit = 1'b1;
        end
      end
    end
  end

  // Decode waits on a hazard or when there is no free slot
  assign related = dec.vld & (hit | full);

  // No new entry while the pipe drains under fake_gen
  assign alloc   = dec.vld & dec.rd_en & ~related & ~fake_gen;
  assign dealloc = retire & (count != '0);

  always_comb begin
    count_nxt = count;
    if (alloc && !dealloc) begin
      count_nxt = count + 1'b1;
    end else if (dealloc && !alloc) begin
      count_nxt = count - 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Pointers, count and valid bits
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      vld_q   <= '0;
      empty_q <= 1'b1;
    end else begin
      if (alloc) begin
        vld_q[wr_ptr] <= 1'b1;
        // Wrap for depths that are not a power of two
        wr_ptr <= (wr_ptr == PTR_W'(OITF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (dealloc) begin
        vld_q[rd_ptr] <= 1'b0;
        rd_ptr <= (rd_ptr == PTR_W'(OITF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count   <= count_nxt;
      empty_q <= (count_nxt == '0);
    end
  end

  // Destination register of each new entry
  always_ff @(posedge clk) begin
    if (alloc) begin
      rd_tab[wr_ptr] <= dec.rd;
    end
  end

  assign status.related = related;
  assign status.empty   = empty_q;

  // ----------------------------------------------------------
  // Checks
  // Retire strobe from the pipe must match a tracked entry
  a_no_retire_empty : assert property (
    @(posedge clk) disable iff (!rstn) retire |-> !empty_q
  );

  // A new entry never lands on a slot still in flight
  a_no_alloc_full : assert property (
    @(posedge clk) disable iff (!rstn) alloc |-> !vld_q[wr_ptr]
  );

endmodule

`default_nettype wire

//--- rtl/trap_unit.sv
// Trap unit
// Holds mtvec, epc and the interrupt enable bit; turns the irq level
// into a single entry pulse and mret_exec into a return pulse
`timescale 1ns/1ps
`default_nettype none

module trap_unit (
  input  wire                                clk,
  input  wire                                rstn,
  input  wire                                irq,
  input  wire                                mret_exec,
  input  wire [pipe_ctrl_pkg::PC_DW-1:0]     cur_pc,
  input  wire                                csr_we,
  input  wire [pipe_ctrl_pkg::PC_DW-1:0]     csr_wdata,
  output pipe_ctrl_pkg::trap_req_t           trap
);

  // ----------------------------------------------------------
  // State
  logic                            en_q;
  logic                            req_q;
  logic                            mret_q;
  logic [pipe_ctrl_pkg::PC_DW-1:0] mtvec_q;
  logic [pipe_ctrl_pkg::PC_DW-1:0] epc_q;

  logic take_irq;
  logic take_mret;

  // Interrupt taken only while enabled
  assign take_irq  = irq & en_q;

  // Entry has priority over a return in the same cycle
  assign take_mret = mret_exec & ~take_irq;

  // ----------------------------------------------------------
  // Request pulses and enable bit
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      req_q  <= 1'b0;
      mret_q <= 1'b0;
      en_q   <= 1'b1;
    end else begin
      req_q  <= take_irq;
      mret_q <= take_mret;
      if (take_irq) begin
        // Masked until the handler returns
        en_q <= 1'b0;
      end else if (take_mret) begin
        en_q <= 1'b1;
      end
    end
  end

  // Trap vector, written through the CSR port
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mtvec_q <= '0;
    end else if (csr_we) begin
      mtvec_q <= csr_wdata;
    end
  end

  // Return address captured at interrupt entry
  always_ff @(posedge clk) begin
    if (take_irq) begin
      epc_q <= cur_pc;
    end
  end

  // ----------------------------------------------------------
  // Outputs
  assign trap.req   = req_q;
  assign trap.mret  = mret_q;
  assign trap.mtvec = mtvec_q;
  assign trap.epc   = epc_q;

  // ----------------------------------------------------------
  // Checks
  // Entry and return never overlap
  a_req_mret_excl : assert property (
    @(posedge clk) disable iff (!rstn) !(trap.req && trap.mret)
  );

  // A held irq gives one entry until a return re-enables it
  a_req_single : assert property (
    @(posedge clk) disable iff (!rstn) trap.req |=> !trap.req
  );

endmodule

`default_nettype wire

//--- rtl/pipe_control.sv
// Pipeline controller
// Merges hazard, trap, jump and fence.i events into per-stage stalls,
// a flush pulse, a fake-valid drain flag and the fetch redirect
`timescale 1ns/1ps
`default_nettype none

module pipe_control (
  input  wire                        clk,
  input  wire                        rstn,
  input  pipe_ctrl_pkg::oitf_stat_t  status,
  input  pipe_ctrl_pkg::trap_req_t   trap,
  input  wire                        jump_en,
  input  wire                        fence_i,
  input  wire                        wb_alu_stall,
  input  wire                        fetch_idle,
  output pipe_ctrl_pkg::stall_t      stall,
  output logic                       fake_gen,
  output logic                       flush_start,
  output pipe_ctrl_pkg::redirect_t   redirect
);

  // ----------------------------------------------------------
  // State
  logic                        fake_q;
  logic                        empty_1d;
  logic                        mret_pend;
  pipe_ctrl_pkg::flush_cause_e cause_q;
  pipe_ctrl_pkg::flush_cause_e cur_cause;

  logic empty_rise;
  logic real_mret;

  // Any event that throws away younger instructions
  assign flush_start = jump_en | fence_i | trap.req | trap.mret;

  // Current cause, interrupt first
  always_comb begin
    if (trap.req) begin
      cur_cause = pipe_ctrl_pkg::CAUSE_IRQ;
    end else if (trap.mret) begin
      cur_cause = pipe_ctrl_pkg::CAUSE_MRET;
    end else if (jump_en) begin
      cur_cause = pipe_ctrl_pkg::CAUSE_JUMP;
    end else if (fence_i) begin
      cur_cause = pipe_ctrl_pkg::CAUSE_FENCEI;
    end else begin
      cur_cause = pipe_ctrl_pkg::CAUSE_NONE;
    end
  end

  // ----------------------------------------------------------
  // Fake flag: set by a flush, cleared once drained and fetch idle
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fake_q  <= 1'b0;
      cause_q <= pipe_ctrl_pkg::CAUSE_NONE;
    end else begin
      if (flush_start) begin
        fake_q  <= 1'b1;
        cause_q <= cur_cause;
      end else if (status.empty && fetch_idle) begin
        fake_q <= 1'b0;
      end
    end
  end

  // Shared by every stage
  assign fake_gen = fake_q;

  // Stage stalls
  assign stall.pc  = status.related | wb_alu_stall | fake_q;
  assign stall.ifu = status.related | wb_alu_stall;
  assign stall.de  = status.related | wb_alu_stall;
  assign stall.alu = wb_alu_stall;

  // ----------------------------------------------------------
  // Return redirect waits for the OITF to drain
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      // Table is empty out of reset, so no edge right after it
      empty_1d  <= 1'b1;
      mret_pend <= 1'b0;
    end else begin
      empty_1d <= status.empty;
      if (trap.mret) begin
        mret_pend <= 1'b1;
      end else if (status.empty) begin
        mret_pend <= 1'b0;
      end
    end
  end

  assign empty_rise = status.empty & ~empty_1d;

  // Immediate if already drained, else on the drain edge
  assign real_mret = (trap.mret & status.empty) | (mret_pend & empty_rise);

  // Interrupt goes to mtvec, return to epc
  assign redirect.vld = trap.req | real_mret;
  assign redirect.pc  = trap.req ? trap.mtvec : trap.epc;

  // ----------------------------------------------------------
  // Checks
  // Only trap entry or return may move the fetch PC
  a_redirect_cause : assert property (
    @(posedge clk) disable iff (!rstn)
      redirect.vld |->
        (cur_cause == pipe_ctrl_pkg::CAUSE_IRQ)  ||
        (cur_cause == pipe_ctrl_pkg::CAUSE_MRET) ||
        (cause_q   == pipe_ctrl_pkg::CAUSE_MRET)
  );

endmodule

`default_nettype wire

//--- rtl/pipe_ctrl_top.sv
// Pipeline control top level
// Ties the OITF, the trap unit and the pipeline controller together
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_top #(
  parameter int OITF_DEPTH = 4
) (
  input  wire                            clk,
  input  wire                            rstn,
  // Decode and retire
  input  pipe_ctrl_pkg::dec_t            dec,
  input  wire                            retire,
  // Fetch and execute events
  input  wire                            fetch_idle,
  input  wire                            jump_en,
  input  wire                            fence_i,
  input  wire                            mret_exec,
  input  wire                            wb_alu_stall,
  // Interrupt and CSR
  input  wire                            irq,
  input  wire [pipe_ctrl_pkg::PC_DW-1:0] cur_pc,
  input  wire                            csr_we,
  input  wire [pipe_ctrl_pkg::PC_DW-1:0] csr_wdata,
  // Control outputs
  output pipe_ctrl_pkg::stall_t          stall,
  output logic                           fake_gen,
  output logic                           flush_start,
  output pipe_ctrl_pkg::redirect_t       redirect
);

  // ----------------------------------------------------------
  // Internal buses
  pipe_ctrl_pkg::oitf_stat_t status;
  pipe_ctrl_pkg::trap_req_t  trap;

  oitf_tracker #(
    .OITF_DEPTH (OITF_DEPTH)
  ) u_oitf (
    .clk      (clk),
    .rstn     (rstn),
    .dec      (dec),
    .retire   (retire),
    .fake_gen (fake_gen),
    .status   (status)
  );

  trap_unit u_trap (
    .clk       (clk),
    .rstn      (rstn),
    .irq       (irq),
    .mret_exec (mret_exec),
    .cur_pc    (cur_pc),
    .csr_we    (csr_we),
    .csr_wdata (csr_wdata),
    .trap      (trap)
  );

  // Drain flag loops back to block OITF allocation
  pipe_control u_ctrl (
    .clk          (clk),
    .rstn         (rstn),
    .status       (status),
    .trap         (trap),
    .jump_en      (jump_en),
    .fence_i      (fence_i),
    .wb_alu_stall (wb_alu_stall),
    .fetch_idle   (fetch_idle),
    .stall        (stall),
    .fake_gen     (fake_gen),
    .flush_start  (flush_start),
    .redirect     (redirect)
  );

endmodule

`default_nettype wire

//--- sim/tb_pipe_ctrl.sv
// Pipeline control testbench
// Table-driven stimulus on the top level; every cycle the stalls, the
// flush pulse, the drain flag and the redirect are checked
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_ctrl;

  localparam int DEPTH  = 4;
  localparam int PC_DW  = pipe_ctrl_pkg::PC_DW;
  localparam int REG_AW = pipe_ctrl_pkg::REG_AW;
  localparam int MARGIN = 40;

  // One cycle of DUT inputs
  typedef struct packed {
    pipe_ctrl_pkg::dec_t dec;
    logic                retire;
    logic                fetch_idle;
    logic                jump_en;
    logic                fence_i;
    logic                mret_exec;
    logic                wb_alu_stall;
    logic                irq;
    logic [PC_DW-1:0]    cur_pc;
    logic                csr_we;
    logic [PC_DW-1:0]    csr_wdata;
  } vec_t;

  // Observed outputs; same layout for expected values and care mask
  typedef struct packed {
    pipe_ctrl_pkg::stall_t stall;
    logic                  fake_gen;
    logic                  flush_start;
    logic                  rd_vld;
    logic [PC_DW-1:0]      rd_pc;
  } obs_t;

  logic                        clk;
  logic                        rstn;
  pipe_ctrl_pkg::dec_t         dec;
  logic                        retire;
  logic                        fetch_idle;
  logic                        jump_en;
  logic                        fence_i;
  logic                        mret_exec;
  logic                        wb_alu_stall;
  logic                        irq;
  logic [PC_DW-1:0]            cur_pc;
  logic                        csr_we;
  logic [PC_DW-1:0]            csr_wdata;
  pipe_ctrl_pkg::stall_t       stall;
  logic                        fake_gen;
  logic                        flush_start;
  pipe_ctrl_pkg::redirect_t    redirect;

  // Stimulus table, one entry per cycle
  string names[$];
  vec_t  vecs[$];
  obs_t  exps[$];
  obs_t  cares[$];
  bit    table_done;

  // Trap state model and random source
  logic [PC_DW-1:0] model_mtvec;
  logic [PC_DW-1:0] model_epc;
  logic             model_en;
  logic [31:0]      rng;

  int errors;
  int checks;
  int tests;
  int bad_tests;
  int test_errs;
  int row;

  pipe_ctrl_top #(
    .OITF_DEPTH (DEPTH)
  ) DUT (
    .clk          (clk),
    .rstn         (rstn),
    .dec          (dec),
    .retire       (retire),
    .fetch_idle   (fetch_idle),
    .jump_en      (jump_en),
    .fence_i      (fence_i),
    .mret_exec    (mret_exec),
    .wb_alu_stall (wb_alu_stall),
    .irq          (irq),
    .cur_pc       (cur_pc),
    .csr_we       (csr_we),
    .csr_wdata    (csr_wdata),
    .stall        (stall),
    .fake_gen     (fake_gen),
    .flush_start  (flush_start),
    .redirect     (redirect)
  );

  // ----------------------------------------------------------
  // Helpers
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_next();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Register 1..31, never x0
  function automatic logic [REG_AW-1:0] rand_reg();
    return REG_AW'(rand_next() % 31 + 1);
  endfunction

  // Quiet cycle, fetch idle
  function automatic vec_t idle_vec();
    vec_t v;
    v = '0;
    v.fetch_idle = 1'b1;
    return v;
  endfunction

  // Stall bits in pc, ifu, de, alu order
  function automatic obs_t make_obs(input logic [3:0] st, input logic fk, input logic fl,
                                    input logic rv, input logic [PC_DW-1:0] rpc);
    obs_t o;
    o.stall       = pipe_ctrl_pkg::stall_t'(st);
    o.fake_gen    = fk;
    o.flush_start = fl;
    o.rd_vld      = rv;
    o.rd_pc       = rpc;
    return o;
  endfunction

  // mtvec, epc and enable bit as the trap rules define them
  task automatic model_step(input vec_t v);
    if (v.irq && model_en) begin
      model_epc = v.cur_pc;
      model_en  = 1'b0;
    end else if (v.mret_exec) begin
      model_en = 1'b1;
    end
    if (v.csr_we) begin
      model_mtvec = v.csr_wdata;
    end
  endtask

  // Redirect pc only matters while the pulse is expected
  task automatic add_row(input string name, input vec_t v, input obs_t e);
    obs_t c;
    c = '1;
    if (!e.rd_vld) begin
      c.rd_pc = '0;
    end
    names.push_back(name);
    vecs.push_back(v);
    exps.push_back(e);
    cares.push_back(c);
    model_step(v);
  endtask

  task automatic apply_vec(input vec_t v);
    dec          <= v.dec;
    retire       <= v.retire;
    fetch_idle   <= v.fetch_idle;
    jump_en      <= v.jump_en;
    fence_i      <= v.fence_i;
    mret_exec    <= v.mret_exec;
    wb_alu_stall <= v.wb_alu_stall;
    irq          <= v.irq;
    cur_pc       <= v.cur_pc;
    csr_we       <= v.csr_we;
    csr_wdata    <= v.csr_wdata;
  endtask

  // ----------------------------------------------------------
  // Stimulus table
  task automatic build_table();
    vec_t             v;
    logic [REG_AW-1:0] r;
    logic [31:0]      base;
    logic [PC_DW-1:0] pc1;
    int               i;
    // RAW hazard: writer in flight, then a reader of it
    r = rand_reg();
    v = idle_vec();
    v.dec.vld   = 1'b1;
    v.dec.rd_en = 1'b1;
    v.dec.rd    = r;
    add_row("raw_hazard", v, make_obs(4'b0000, 1'b0, 1'b0, 1'b0, '0));
    v = idle_vec();
    v.dec.vld    = 1'b1;
    v.dec.rs1_en = 1'b1;
    v.dec.rs1    = r;
    add_row("raw_hazard", v, make_obs(4'b1110, 1'b0, 1'b0, 1'b0, '0));
    v.retire = 1'b1;
    add_row("raw_hazard", v, make_obs(4'b1110, 1'b0, 1'b0, 1'b0, '0));
    v.retire = 1'b0;
    add_row("raw_hazard", v, make_obs(4'b0000, 1'b0, 1'b0, 1'b0, '0));
    // Full table, distinct destinations and no sources
    base = rand_next();
    for (i = 0; i < DEPTH; i++) begin
      v = idle_vec();
      v.dec.vld   = 1'b1;
      v.dec.rd_en = 1'b1;
      v.dec.rd    = REG_AW'((base + i) % 31 + 1);
      add_row("full_table", v, make_obs(4'b0000, 1'b0, 1'b0, 1'b0, '0));
    end
    v.dec.rd = rand_reg();
    add_row("full_table", v, make_obs(4'b1110, 1'b0, 1'b0, 1'b0, '0));
    v.retire = 1'b1;
    add_row("full_table", v, make_obs(4'b1110, 1'b0, 1'b0, 1'b0, '0));
    // Slot freed, the waiting writer goes in
    v.retire = 1'b0;
    add_row("full_table", v, make_obs(4'b0000, 1'b0, 1'b0, 1'b0, '0));
    for (i = 0; i < DEPTH; i++) begin
      v = idle_vec();
      v.retire = 1'b1;
      add_row("full_table", v, make_obs(4'b0000, 1'b0, 1'b0, 1'b0, '0));
    end
    // Jump flush with fetch still busy
    r = rand_reg();
    v = idle_vec();
    v.jump_en    = 1'b1;
    v.fetch_idle = 1'b0;
    add_row("jump_flush", v, make_obs(4'b0000, 1'b0, 1'b1, 1'b0, '0));
    v = idle_vec();
    v.fetch_idle = 1'b0;
    v.dec.vld    = 1'b1;
    v.dec.rd_en  = 1'b1;
    v.dec.rd     = r;
    add_row("jump_flush", v, make_obs(4'b1000, 1'b1, 1'b0, 1'b0, '0));
    // Writer above must not be tracked, so no hazard here
    v.dec.rd_en  = 1'b0;
    v.dec.rs1_en = 1'b1;
    v.dec.rs1    = r;
    add_row("jump_flush", v, make_obs(4'b1000, 1'b1, 1'b0, 1'b0, '0));
    v = idle_vec();
    add_row("jump_flush", v, make_obs(4'b1000, 1'b1, 1'b0, 1'b0, '0));
    add_row("jump_flush", v, make_obs(4'b0000, 1'b0, 1'b0, 1'b0, '0));
    // Interrupt entry
    v = idle_vec();
    v.csr_we    = 1'b1;
    v.csr_wdata = (rand_next() & 32'hffff_fffc) | 32'h0000_0100;
    add_row("interrupt", v, make_obs(4'b0000, 1'b0, 1'b0, 1'b0, '0));
    pc1 = rand_next() & 32'hffff_fffc;
    v = idle_vec();
    v.irq    = 1'b1;
    v.cur_pc = pc1;
    add_row("interrupt", v, make_obs(4'b0000, 1'b0, 1'b0, 1'b0, '0));
    v.cur_pc = pc1 + 32'd4;
    add_row("interrupt", v, make_obs(4'b0000, 1'b0, 1'b1, 1'b1, model_mtvec));
    // irq still held, masked
    v.cur_pc = pc1 + 32'd8;
    add_row("interrupt", v, make_obs(4'b1000, 1'b1, 1'b0, 1'b0, '0));
    add_row("interrupt", v, make_obs(4'b0000, 1'b0, 1'b0, 1'b0, '0));
    // Return while one writer is still in flight
    v = idle_vec();
    v.dec.vld   = 1'b1;
    v.dec.rd_en = 1'b1;
    v.dec.rd    = rand_reg();
    add_row("mret_in_flight", v, make_obs(4'b0000, 1'b0, 1'b0, 1'b0, '0));
    v = idle_vec();
    v.mret_exec = 1'b1;
    add_row("mret_in_flight", v, make_obs(4'b0000, 1'b0, 1'b0, 1'b0, '0));
    v = idle_vec();
    add_row("mret_in_flight", v, make_obs(4'b0000, 1'b0, 1'b1, 1'b0, '0));
    v.retire = 1'b1;
    add_row("mret_in_flight", v, make_obs(4'b1000, 1'b1, 1'b0, 1'b0, '0));
    v = idle_vec();
    add_row("mret_in_flight", v, make_obs(4'b1000, 1'b1, 1'b0, 1'b1, model_epc));
    add_row("mret_in_flight", v, make_obs(4'b0000, 1'b0, 1'b0, 1'b0, '0));
    // Write-back stall holds every stage
    v = idle_vec();
    v.wb_alu_stall = 1'b1;
    add_row("wb_stall", v, make_obs(4'b1111, 1'b0, 1'b0, 1'b0, '0));
    v = idle_vec();
    add_row("wb_stall", v, make_obs(4'b0000, 1'b0, 1'b0, 1'b0, '0));
  endtask

  // ----------------------------------------------------------
  // Checking and reporting
  task automatic check_row(input int idx);
    obs_t act;
    act.stall       = stall;
    act.fake_gen    = fake_gen;
    act.flush_start = flush_start;
    act.rd_vld      = redirect.vld;
    act.rd_pc       = redirect.pc;
    checks++;
    assert (((act ^ exps[idx]) & cares[idx]) == '0) else begin
      $display("mismatch %s row %0d: expected %h actual %h care %h",
               names[idx], idx, exps[idx], act, cares[idx]);
      errors++;
      test_errs++;
    end
  endtask

  task automatic report_test(input int idx);
    tests++;
    if (test_errs == 0) begin
      $display("%s: ok", names[idx]);
    end else begin
      $display("%s: %0d errors", names[idx], test_errs);
      bad_tests++;
    end
    test_errs = 0;
  endtask

  // ----------------------------------------------------------
  // Clock, main sequence and watchdog
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rng         = 32'h1ccf;
    model_en    = 1'b1;
    model_mtvec = '0;
    model_epc   = '0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    bad_tests   = 0;
    test_errs   = 0;
    table_done  = 1'b0;
    rstn        = 1'b0;
    apply_vec(idle_vec());
    build_table();
    table_done = 1'b1;
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    for (row = 0; row < vecs.size(); row++) begin
      @(posedge clk);
      apply_vec(vecs[row]);
      // Outputs settled half a cycle after the drive edge
      @(negedge clk);
      check_row(row);
      if (row == vecs.size() - 1 || names[row + 1] != names[row]) begin
        report_test(row);
      end
    end
    @(posedge clk);
    apply_vec(idle_vec());
    $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
             tests, bad_tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Table length plus reset and a margin, in clock cycles
  initial begin
    wait (table_done);
    repeat (vecs.size() + 2 + MARGIN) @(posedge clk);
    $display("watchdog expired, the run did not finish in %0d cycles",
             vecs.size() + 2 + MARGIN);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
rtl/pipe_ctrl_pkg.sv
rtl/oitf_tracker.sv
rtl/trap_unit.sv
rtl/pipe_control.sv
rtl/pipe_ctrl_top.sv
sim/tb_pipe_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pipe_ctrl
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
